// ==== compile.f ====
+incdir+source
source/spi_pkg.sv
source/spi_clk_gen.sv
source/spi_cmd_stage.sv
source/spi_shift_engine.sv
source/spi_rsp_stage.sv
source/spi_master_top.sv
verification/tb_clk_gen.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// ==== source/spi_cfg.svh ====
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// Frame layout
`define SPI_FRAME_W 32
`define SPI_ADDR_W  7
`define SPI_DATA_W  24

// SCK half-period in CLK50MHZ cycles
`define SPI_DIV     2

`endif

// ==== source/spi_clk_gen.sv ====
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_clk_gen
	import spi_pkg::*;
(
	input  logic CLK50MHZ,
	input  logic RST,
	output logic sck_level,
	output logic sck_rise,
	output logic sck_fall
);

	spi_div_cnt_t cnt;
	logic         last;

	// Final cycle of the current half-period
	assign last = (cnt == spi_div_cnt_t'(`SPI_DIV - 1));

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt       <= '0;
			sck_level <= 1'b0;
		end else if (last) begin
			cnt       <= '0;
			sck_level <= ~sck_level;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Pulses lead the level toggle by one cycle
	assign sck_rise = last & ~sck_level;
	assign sck_fall = last & sck_level;

endmodule

// ==== source/spi_cmd_stage.sv ====
`timescale 1ns/1ps

module spi_cmd_stage
	import spi_pkg::*;
(
	input  logic       CLK50MHZ,
	input  logic       RST,
	// Command side
	input  logic       cmd_valid,
	output logic       cmd_ready,
	input  logic       cmd_read,
	input  spi_addr_t  cmd_addr,
	input  spi_data_t  cmd_data,
	// Engine side
	output logic       frame_valid,
	input  logic       frame_ready,
	output spi_frame_u tx_frame
);

	logic       full;
	spi_frame_u frame_q;

	////////////////////////////////////////////////////////////
	// Holding register control
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			full <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			full <= 1'b1;
		end else if (frame_valid && frame_ready) begin
			full <= 1'b0;
		end
	end

	// Pack the command into the field view
	always_ff @(posedge CLK50MHZ) begin
		if (cmd_valid && cmd_ready) begin
			frame_q.f.read <= cmd_read;
			frame_q.f.addr <= cmd_addr;
			frame_q.f.data <= cmd_data;
		end
	end

	assign cmd_ready   = ~full;
	assign frame_valid = full;
	assign tx_frame    = frame_q;

endmodule

// ==== source/spi_master_top.sv ====
`timescale 1ns/1ps

module spi_master_top
	import spi_pkg::*;
(
	input  logic      CLK50MHZ,
	input  logic      RST,
	// Commands
	input  logic      cmd_valid,
	output logic      cmd_ready,
	input  logic      cmd_read,
	input  spi_addr_t cmd_addr,
	input  spi_data_t cmd_data,
	// Responses
	output logic      rsp_valid,
	input  logic      rsp_ready,
	output logic      rsp_read,
	output spi_addr_t rsp_addr,
	output spi_data_t rsp_data,
	// SPI pins
	output logic      spi_cs,
	output logic      spi_sck,
	output logic      spi_mosi,
	input  logic      spi_miso
);

	logic       sck_level;
	logic       sck_rise;
	logic       sck_fall;
	logic       frame_valid;
	logic       frame_ready;
	spi_frame_u tx_frame;
	logic       rx_valid;
	logic       rx_ready;
	spi_frame_u rx_frame;

	////////////////////////////////////////////////////////////
	// Divider and pipeline stages
	////////////////////////////////////////////////////////////
	spi_clk_gen i_spi_clk_gen (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.sck_level (sck_level),
		.sck_rise  (sck_rise),
		.sck_fall  (sck_fall)
	);

	spi_cmd_stage i_spi_cmd_stage (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_read    (cmd_read),
		.cmd_addr    (cmd_addr),
		.cmd_data    (cmd_data),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready),
		.tx_frame    (tx_frame)
	);

	spi_shift_engine i_spi_shift_engine (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.sck_level   (sck_level),
		.sck_rise    (sck_rise),
		.sck_fall    (sck_fall),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready),
		.tx_frame    (tx_frame),
		.rx_valid    (rx_valid),
		.rx_ready    (rx_ready),
		.rx_frame    (rx_frame),
		.spi_cs      (spi_cs),
		.spi_sck     (spi_sck),
		.spi_miso    (spi_miso),
		.spi_mosi    (spi_mosi)
	);

	spi_rsp_stage i_spi_rsp_stage (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.rx_valid  (rx_valid),
		.rx_ready  (rx_ready),
		.rx_frame  (rx_frame),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_read  (rsp_read),
		.rsp_addr  (rsp_addr),
		.rsp_data  (rsp_data)
	);

endmodule

// ==== source/spi_pkg.sv ====
`include "spi_cfg.svh"

package spi_pkg;

	////////////////////////////////////////////////////////////
	// Register access fields
	////////////////////////////////////////////////////////////
	typedef logic [`SPI_ADDR_W-1:0] spi_addr_t;
	typedef logic [`SPI_DATA_W-1:0] spi_data_t;

	// Divider counter, wide enough for SPI_DIV of one
	typedef logic [$clog2(`SPI_DIV + 1)-1:0] spi_div_cnt_t;

	// One SPI frame, seen as a shift word or as a register command
	typedef union packed {
		logic [`SPI_FRAME_W-1:0] raw;
		struct packed {
			logic      read;
			spi_addr_t addr;
			spi_data_t data;
		} f;
	} spi_frame_u;

endpackage

// ==== source/spi_rsp_stage.sv ====
`timescale 1ns/1ps

module spi_rsp_stage
	import spi_pkg::*;
(
	input  logic       CLK50MHZ,
	input  logic       RST,
	// Engine side
	input  logic       rx_valid,
	output logic       rx_ready,
	input  spi_frame_u rx_frame,
	// Response side
	output logic       rsp_valid,
	input  logic       rsp_ready,
	output logic       rsp_read,
	output spi_addr_t  rsp_addr,
	output spi_data_t  rsp_data
);

	logic       full;
	spi_frame_u frame_q;

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			full <= 1'b0;
		end else if (rx_valid && rx_ready) begin
			full <= 1'b1;
		end else if (rsp_valid && rsp_ready) begin
			full <= 1'b0;
		end
	end

	// Received word, kept raw and decoded on the way out
	always_ff @(posedge CLK50MHZ) begin
		if (rx_valid && rx_ready)
			frame_q.raw <= rx_frame.raw;
	end

	assign rx_ready  = ~full;
	assign rsp_valid = full;
	assign rsp_read  = frame_q.f.read;
	assign rsp_addr  = frame_q.f.addr;
	assign rsp_data  = frame_q.f.data;

endmodule

// ==== source/spi_shift_engine.sv ====
`timescale 1ns/1ps

module spi_shift_engine
	import spi_pkg::*;
(
	input  logic       CLK50MHZ,
	input  logic       RST,
	// Divider
	input  logic       sck_level,
	input  logic       sck_rise,
	input  logic       sck_fall,
	// Command stage
	input  logic       frame_valid,
	output logic       frame_ready,
	input  spi_frame_u tx_frame,
	// Response stage
	output logic       rx_valid,
	input  logic       rx_ready,
	output spi_frame_u rx_frame,
	// SPI pins
	output logic       spi_cs,
	output logic       spi_sck,
	input  logic       spi_miso,
	output logic       spi_mosi
);

	localparam int FRAME_W = $bits(spi_frame_u);
	localparam int CNT_W   = $clog2(FRAME_W + 1);

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_LEAD  = 3'd1;
	localparam logic [2:0] ST_SHIFT = 3'd2;
	localparam logic [2:0] ST_TRAIL = 3'd3;
	localparam logic [2:0] ST_HOLD  = 3'd4;

	logic [2:0]       state;
	logic [2:0]       state_nxt;
	logic [CNT_W-1:0] bit_cnt;
	logic             bit_done;
	logic             shift_rise;
	logic             shift_fall;
	logic             level_nxt;
	logic             last_bit;
	spi_frame_u       shreg;

	// Start only on a rising pulse so the lead half-period is whole
	assign frame_ready = (state == ST_IDLE) && sck_rise;
	assign shift_rise  = (state == ST_SHIFT) && sck_rise;
	assign shift_fall  = (state == ST_SHIFT) && sck_fall;
	assign bit_done    = (bit_cnt == CNT_W'(FRAME_W));
	assign level_nxt   = sck_level ^ (sck_rise | sck_fall);
	assign rx_frame    = shreg;

	////////////////////////////////////////////////////////////
	// Frame sequencing
	////////////////////////////////////////////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:  if (frame_valid && frame_ready) state_nxt = ST_LEAD;
			ST_LEAD:  if (sck_fall) state_nxt = ST_SHIFT;
			ST_SHIFT: if (sck_fall && bit_done) state_nxt = ST_TRAIL;
			ST_TRAIL: begin
				if (sck_rise) begin
					// Response still pending keeps CS high and blocks the next frame
					state_nxt = (rx_valid && !rx_ready) ? ST_HOLD : ST_IDLE;
				end
			end
			ST_HOLD:  if (rx_ready) state_nxt = ST_IDLE;
			default:  state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state    <= ST_IDLE;
			spi_cs   <= 1'b1;
			spi_sck  <= 1'b0;
			spi_mosi <= 1'b0;
			bit_cnt  <= '0;
			last_bit <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			state    <= state_nxt;
			spi_cs   <= ~(state_nxt == ST_LEAD || state_nxt == ST_SHIFT ||
				state_nxt == ST_TRAIL);
			spi_sck  <= (state_nxt == ST_SHIFT) && level_nxt;
			last_bit <= shift_rise && (bit_cnt == CNT_W'(FRAME_W - 1));
			if (frame_valid && frame_ready) begin
				bit_cnt  <= '0;
				spi_mosi <= tx_frame.raw[FRAME_W-1];
			end
			if (shift_rise)
				bit_cnt <= bit_cnt + 1'b1;
			// MOSI moves on the falling edge, idles low after the last bit
			if (shift_fall)
				spi_mosi <= bit_done ? 1'b0 : shreg.raw[FRAME_W-1];
			if (last_bit)
				rx_valid <= 1'b1;
			else if (rx_valid && rx_ready)
				rx_valid <= 1'b0;
		end
	end

	// Full-duplex shifter, MISO enters at the LSB
	always_ff @(posedge CLK50MHZ) begin
		if (frame_valid && frame_ready)
			shreg <= tx_frame;
		else if (shift_rise)
			shreg.raw <= {shreg.raw[FRAME_W-2:0], spi_miso};
	end

endmodule

// ==== verification/spi_slave_model.sv ====
`timescale 1ns/1ps

module spi_slave_model
	import spi_pkg::*;
(
	input  logic RST,
	input  logic spi_cs,
	input  logic spi_sck,
	input  logic spi_mosi,
	output logic spi_miso,
	output int   frame_cnt,
	output int   fault_cnt
);

	spi_data_t   regs [0:127];
	spi_frame_u  rx_word;
	spi_frame_u  tx_word;
	logic [31:0] tx_shift;
	int          rise_cnt;
	logic        cs_q;
	logic        sck_q;
	logic        miso_bit = 1'b0;

	assign spi_miso = miso_bit;

	// Power-on contents, distinct for every address
	function automatic spi_data_t fill_value(input spi_addr_t a);
		return {a, ~a, a, 3'b101};
	endfunction

	// Edges are found by comparing against the last seen pin levels
	always @(RST or spi_cs or spi_sck) begin
		if (RST) begin
			for (int a = 0; a < 128; a++)
				regs[a] = fill_value(spi_addr_t'(a));
			tx_word.raw = '0;
			rx_word.raw = '0;
			tx_shift    = '0;
			rise_cnt    = 0;
			frame_cnt   = 0;
			fault_cnt   = 0;
			miso_bit    = 1'b0;
		end else begin
			// Frame start, first bit goes out before the first rising edge
			if (cs_q && !spi_cs) begin
				if (spi_sck) begin
					$display("Protocol fault at %0t: SCK was high when CS fell", $time);
					fault_cnt++;
				end
				rise_cnt    = 0;
				rx_word.raw = '0;
				tx_shift    = tx_word.raw;
				miso_bit    = tx_shift[31];
			end
			if (!spi_cs && !sck_q && spi_sck) begin
				rx_word.raw = {rx_word.raw[30:0], spi_mosi};
				rise_cnt++;
			end
			if (!spi_cs && sck_q && !spi_sck) begin
				tx_shift = tx_shift << 1;
				miso_bit = tx_shift[31];
			end
			// Frame end, commit a write and build the next reply
			if (!cs_q && spi_cs) begin
				frame_cnt++;
				if (rise_cnt != 32) begin
					$display("Protocol fault at %0t: frame had %0d SCK rising edges", $time,
						rise_cnt);
					fault_cnt++;
				end
				if (!rx_word.f.read)
					regs[rx_word.f.addr] = rx_word.f.data;
				tx_word.f.read = rx_word.f.read;
				tx_word.f.addr = rx_word.f.addr;
				tx_word.f.data = regs[rx_word.f.addr];
				miso_bit       = 1'b0;
			end
		end
		cs_q  = spi_cs;
		sck_q = spi_sck;
	end

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== verification/tb_spi_master.sv ====
`timescale 1ns/1ps
`include "spi_cfg.svh"

module tb_spi_master
	import spi_pkg::*;
();

	// Budget of 40 SCK periods per command
	localparam int SCK_CYCLES  = 2 * `SPI_DIV;
	localparam int CMD_CYCLES  = 40 * SCK_CYCLES;
	localparam int N_CMDS      = 27;
	localparam int WATCHDOG_NS = (N_CMDS + 15) * CMD_CYCLES * 20;

	logic       CLK50MHZ;
	logic       RST;
	logic       cmd_valid;
	logic       cmd_ready;
	logic       cmd_read;
	spi_addr_t  cmd_addr;
	spi_data_t  cmd_data;
	logic       rsp_valid;
	logic       rsp_ready;
	logic       rsp_read;
	spi_addr_t  rsp_addr;
	spi_data_t  rsp_data;
	logic       spi_cs;
	logic       spi_sck;
	logic       spi_mosi;
	logic       spi_miso;
	int         frame_cnt;
	int         fault_cnt;

	int         seed       = 71;
	int         val_errs   = 0;
	int         proto_errs = 0;
	int         cmd_cnt    = 0;
	spi_frame_u expect_q [$];
	spi_frame_u exp_rsp;
	spi_data_t  ref_regs [0:127];
	logic       prev_read;
	spi_addr_t  prev_addr;
	bit         first_cmd;

	tb_clk_gen #(.PERIOD_NS(20)) i_tb_clk_gen (.clk(CLK50MHZ));

	spi_master_top i_spi_master_top (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_read  (cmd_read),
		.cmd_addr  (cmd_addr),
		.cmd_data  (cmd_data),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_read  (rsp_read),
		.rsp_addr  (rsp_addr),
		.rsp_data  (rsp_data),
		.spi_cs    (spi_cs),
		.spi_sck   (spi_sck),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso)
	);

	spi_slave_model i_spi_slave_model (
		.RST       (RST),
		.spi_cs    (spi_cs),
		.spi_sck   (spi_sck),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.frame_cnt (frame_cnt),
		.fault_cnt (fault_cnt)
	);

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////
	task automatic check_addr(input spi_addr_t got, input spi_addr_t exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			val_errs++;
		end
	endtask

	task automatic check_data(input spi_data_t got, input spi_data_t exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			val_errs++;
		end
	endtask

	task automatic expect_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
			val_errs++;
		end
	endtask

	function automatic spi_data_t power_on_value(input spi_addr_t a);
		return {a, ~a, a, 3'b101};
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////
	// Reply to frame N echoes frame N-1 with the register it names
	task automatic send_cmd(input logic rd, input spi_addr_t addr, input spi_data_t data);
		spi_frame_u exp;
		if (first_cmd) begin
			exp.raw = '0;
		end else begin
			exp.f.read = prev_read;
			exp.f.addr = prev_addr;
			exp.f.data = ref_regs[prev_addr];
		end
		expect_q.push_back(exp);
		if (!rd)
			ref_regs[addr] = data;
		prev_read = rd;
		prev_addr = addr;
		first_cmd = 1'b0;
		cmd_cnt++;
		@(posedge CLK50MHZ);
		cmd_valid <= 1'b1;
		cmd_read  <= rd;
		cmd_addr  <= addr;
		cmd_data  <= data;
		do @(posedge CLK50MHZ); while (!cmd_ready);
		cmd_valid <= 1'b0;
	endtask

	task automatic send_random();
		logic      rd;
		spi_addr_t addr;
		spi_data_t data;
		rd   = 1'($random(seed));
		// Narrow address range so reads land on written registers
		addr = spi_addr_t'($random(seed)) & 7'h1F;
		data = spi_data_t'($random(seed));
		send_cmd(rd, addr, data);
	endtask

	task automatic wait_drain();
		int cycles;
		int limit;
		cycles = 0;
		limit  = (expect_q.size() + 1) * CMD_CYCLES;
		while (expect_q.size() != 0 && cycles < limit) begin
			@(posedge CLK50MHZ);
			cycles++;
		end
		if (expect_q.size() != 0) begin
			$display("Missing %0d responses after waiting %0d cycles", expect_q.size(), cycles);
			proto_errs += expect_q.size();
			expect_q.delete();
		end
	endtask

	// Response monitor
	always @(posedge CLK50MHZ) begin
		if (!RST && rsp_valid && rsp_ready) begin
			if (expect_q.size() == 0) begin
				$display("Unexpected response at %0t with no command outstanding", $time);
				proto_errs++;
			end else begin
				exp_rsp = expect_q.pop_front();
				expect_level(rsp_read, exp_rsp.f.read, "response read flag");
				check_addr(rsp_addr, exp_rsp.f.addr, "response address");
				check_data(rsp_data, exp_rsp.f.data, "response data");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic reset_dut();
		for (int a = 0; a < 128; a++)
			ref_regs[a] = power_on_value(spi_addr_t'(a));
		first_cmd = 1'b1;
		repeat (16) @(posedge CLK50MHZ);
		RST <= 1'b0;
		@(posedge CLK50MHZ);
	endtask

	task automatic idle_after_reset();
		expect_level(spi_cs, 1'b1, "spi_cs after reset");
		expect_level(spi_sck, 1'b0, "spi_sck after reset");
		expect_level(rsp_valid, 1'b0, "rsp_valid after reset");
		expect_level(cmd_ready, 1'b1, "cmd_ready after reset");
	endtask

	// The read result comes back in the frame after the read
	task automatic write_read_back();
		send_cmd(1'b0, 7'h2A, 24'hC0FFEE);
		send_cmd(1'b1, 7'h2A, 24'h000000);
		send_cmd(1'b1, 7'h05, 24'h000000);
		wait_drain();
	endtask

	task automatic random_stream();
		repeat (20) send_random();
		wait_drain();
	endtask

	task automatic back_pressure();
		int waited;
		@(posedge CLK50MHZ);
		rsp_ready <= 1'b0;
		fork
			repeat (4) send_random();
			begin
				waited = 0;
				while (cmd_ready && waited < 4 * CMD_CYCLES) begin
					@(posedge CLK50MHZ);
					waited++;
				end
				if (cmd_ready) begin
					$display("cmd_ready never fell while responses were held back");
					proto_errs++;
				end
				// Let the engine finish its frame and park
				repeat (2 * CMD_CYCLES) @(posedge CLK50MHZ);
				expect_level(cmd_ready, 1'b0, "cmd_ready with full pipeline");
				expect_level(rsp_valid, 1'b1, "rsp_valid with full pipeline");
				expect_level(spi_cs, 1'b1, "spi_cs while engine holds a frame");
				rsp_ready <= 1'b1;
			end
		join
		wait_drain();
	endtask

	task automatic verify_frames();
		// Last CS rise trails the last response
		repeat (4 * SCK_CYCLES) @(posedge CLK50MHZ);
		if (frame_cnt != cmd_cnt) begin
			$display("Slave saw %0d frames for %0d commands", frame_cnt, cmd_cnt);
			proto_errs++;
		end
		if (fault_cnt != 0) begin
			$display("Slave reported %0d SPI protocol faults", fault_cnt);
			proto_errs += fault_cnt;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		RST       = 1'b1;
		cmd_valid = 1'b0;
		cmd_read  = 1'b0;
		cmd_addr  = '0;
		cmd_data  = '0;
		rsp_ready = 1'b1;
		reset_dut();
		idle_after_reset();
		write_read_back();
		random_stream();
		back_pressure();
		verify_frames();
		$display("Errors: %0d value mismatches, %0d protocol faults", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
